//--- vdiv_params.svh
// sizes and APB offsets; each element array base must be aligned to 4*VDIV_LANES bytes
`ifndef VDIV_PARAMS_SVH
`define VDIV_PARAMS_SVH

// lanes working in parallel, one element each
`define VDIV_LANES 4

// element width, also the APB data width
`define VDIV_XLEN 32

// one quotient bit per step
`define VDIV_ITERS `VDIV_XLEN

// byte offsets, four words per array at stride 4
`define VDIV_ADDR_OP1 8'h00
`define VDIV_ADDR_OP2 8'h10
`define VDIV_ADDR_RES 8'h20

// single words
`define VDIV_ADDR_CTRL 8'h30
`define VDIV_ADDR_STAT 8'h34

`endif

//--- vdiv_pkg.sv
// shared types; widths follow vdiv_params.svh, APB address is fixed at 8 bits
`default_nettype none

`include "vdiv_params.svh"

package vdiv_pkg;

    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } vdiv_op_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } lane_state_e;

    // magnitudes plus the sign and corner-case flags for collect
    typedef struct packed {
        logic [`VDIV_XLEN-1:0] dividend;
        logic [`VDIV_XLEN-1:0] divisor;
        logic                  start;
        logic                  neg_q;
        logic                  neg_r;
        logic                  div_zero;
        logic                  overflow;
    } lane_req_t;

    typedef struct packed {
        logic [`VDIV_XLEN-1:0] quotient;
        logic [`VDIV_XLEN-1:0] remainder;
        logic                  valid;    // one cycle
        logic                  neg_q;
        logic                  neg_r;
        logic                  div_zero;
        logic                  overflow;
    } lane_rsp_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [7:0]            paddr;
        logic [`VDIV_XLEN-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`VDIV_XLEN-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        vdiv_op_e                               opcode;
        logic [`VDIV_LANES-1:0][`VDIV_XLEN-1:0] op1; // dividends
        logic [`VDIV_LANES-1:0][`VDIV_XLEN-1:0] op2; // divisors
    } vdiv_cmd_t;

    typedef struct packed {
        logic [`VDIV_LANES-1:0][`VDIV_XLEN-1:0] res;
    } vdiv_res_t;

endpackage

`default_nettype wire

//--- vdiv_apb_regs.sv
// APB slave without wait states; low two address bits ignored, one operation at a time
`timescale 1ns/1ns
`default_nettype none

`include "vdiv_params.svh"

module vdiv_apb_regs (
    input  wire                  clk_i,
    input  wire                  arst_n_i,
    input  wire vdiv_pkg::apb_req_t apb_i,
    output vdiv_pkg::apb_rsp_t   apb_o,
    output vdiv_pkg::vdiv_cmd_t  cmd_o,
    output logic                 cmd_start_o,
    input  wire vdiv_pkg::vdiv_res_t res_i,
    input  wire                  res_done_i
);

    localparam int IDX_W = $clog2(`VDIV_LANES);
    localparam logic [7:0] ARRAY_MASK = ~(8'(4 * `VDIV_LANES) - 8'd1);

    logic [`VDIV_LANES-1:0][`VDIV_XLEN-1:0] op1_q;
    logic [`VDIV_LANES-1:0][`VDIV_XLEN-1:0] op2_q;
    logic [`VDIV_LANES-1:0][`VDIV_XLEN-1:0] res_q;
    vdiv_pkg::vdiv_op_e opcode_q;
    logic busy_q;
    logic done_q;

    logic [7:0]       addr_w;
    logic [IDX_W-1:0] idx;
    logic access;
    logic is_op1, is_op2, is_res, is_ctrl, is_stat;
    logic mapped;
    logic refused;
    logic wr_ok;
    logic start_ok;

    assign addr_w = {apb_i.paddr[7:2], 2'b00};
    assign idx    = apb_i.paddr[IDX_W+1:2]; // element within an array
    assign access = apb_i.psel & apb_i.penable;

    assign is_op1  = (addr_w & ARRAY_MASK) == `VDIV_ADDR_OP1;
    assign is_op2  = (addr_w & ARRAY_MASK) == `VDIV_ADDR_OP2;
    assign is_res  = (addr_w & ARRAY_MASK) == `VDIV_ADDR_RES;
    assign is_ctrl = addr_w == `VDIV_ADDR_CTRL;
    assign is_stat = addr_w == `VDIV_ADDR_STAT;
    assign mapped  = is_op1 | is_op2 | is_res | is_ctrl | is_stat;

    // operands and control are frozen while the lanes run
    assign refused  = apb_i.pwrite & busy_q & (is_op1 | is_op2 | is_ctrl);
    assign wr_ok    = access & apb_i.pwrite & mapped & ~refused;
    assign start_ok = wr_ok & is_ctrl & apb_i.pwdata[4];

    always_comb begin
        apb_o.pready  = 1'b1;
        apb_o.pslverr = access & (~mapped | refused);
        apb_o.prdata  = '0;
        if (is_op1) begin
            apb_o.prdata = op1_q[idx];
        end else if (is_op2) begin
            apb_o.prdata = op2_q[idx];
        end else if (is_res) begin
            apb_o.prdata = res_q[idx];
        end else if (is_ctrl) begin
            apb_o.prdata = {{(`VDIV_XLEN-2){1'b0}}, opcode_q};
        end else if (is_stat) begin
            apb_o.prdata = {{(`VDIV_XLEN-2){1'b0}}, done_q, busy_q};
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op1_q       <= '0;
            op2_q       <= '0;
            res_q       <= '0;
            opcode_q    <= vdiv_pkg::OP_DIV;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            cmd_start_o <= 1'b0;
        end else begin
            cmd_start_o <= start_ok;
            if (wr_ok && is_op1) begin
                op1_q[idx] <= apb_i.pwdata;
            end
            if (wr_ok && is_op2) begin
                op2_q[idx] <= apb_i.pwdata;
            end
            if (wr_ok && is_ctrl) begin
                opcode_q <= vdiv_pkg::vdiv_op_e'(apb_i.pwdata[1:0]);
            end
            if (start_ok) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end
            if (res_done_i) begin // only arrives while busy
                res_q  <= res_i.res;
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    assign cmd_o.opcode = opcode_q;
    assign cmd_o.op1    = op1_q;
    assign cmd_o.op2    = op2_q;

endmodule

`default_nettype wire

//--- vdiv_dispatch.sv
// converts a command to per-lane magnitudes and flags one cycle after cmd_start_i
`timescale 1ns/1ns
`default_nettype none

`include "vdiv_params.svh"

module vdiv_dispatch (
    input  wire                  clk_i,
    input  wire                  arst_n_i,
    input  wire vdiv_pkg::vdiv_cmd_t cmd_i,
    input  wire                  cmd_start_i,
    output vdiv_pkg::lane_req_t [`VDIV_LANES-1:0] req_o,
    output vdiv_pkg::vdiv_op_e   opcode_o
);

    localparam logic [`VDIV_XLEN-1:0] MOST_NEG = {1'b1, {(`VDIV_XLEN-1){1'b0}}};

    vdiv_pkg::lane_req_t [`VDIV_LANES-1:0] req_d;
    logic is_signed;

    assign is_signed = (cmd_i.opcode == vdiv_pkg::OP_DIV) ||
                       (cmd_i.opcode == vdiv_pkg::OP_REM);

    always_comb begin
        for (int i = 0; i < `VDIV_LANES; i++) begin
            logic [`VDIV_XLEN-1:0] a;
            logic [`VDIV_XLEN-1:0] b;
            logic a_neg;
            logic b_neg;

            a     = cmd_i.op1[i];
            b     = cmd_i.op2[i];
            a_neg = is_signed & a[`VDIV_XLEN-1];
            b_neg = is_signed & b[`VDIV_XLEN-1];

            req_d[i].dividend = a_neg ? -a : a; // MOST_NEG maps onto itself
            req_d[i].divisor  = b_neg ? -b : b;
            req_d[i].start    = 1'b1;
            req_d[i].neg_q    = a_neg ^ b_neg;
            req_d[i].neg_r    = a_neg;        // remainder follows dividend
            req_d[i].div_zero = (b == '0);
            req_d[i].overflow = is_signed && (a == MOST_NEG) && (b == '1);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_o    <= '0;
            opcode_o <= vdiv_pkg::OP_DIV;
        end else if (cmd_start_i) begin
            req_o    <= req_d;
            opcode_o <= cmd_i.opcode;
        end else begin
            for (int i = 0; i < `VDIV_LANES; i++) begin
                req_o[i].start <= 1'b0; // single-cycle start
            end
        end
    end

endmodule

`default_nettype wire

//--- vdiv_lane.sv
// unsigned restoring divider, valid VDIV_ITERS+1 cycles after start; starts in RUN are ignored
`timescale 1ns/1ns
`default_nettype none

`include "vdiv_params.svh"

module vdiv_lane (
    input  wire                  clk_i,
    input  wire                  arst_n_i,
    input  wire vdiv_pkg::lane_req_t req_i,
    output vdiv_pkg::lane_rsp_t  rsp_o
);

    localparam int CNT_W = $clog2(`VDIV_ITERS);

    vdiv_pkg::lane_state_e state_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [`VDIV_XLEN-1:0] quo_q;  // dividend shifts out, quotient shifts in
    logic [`VDIV_XLEN-1:0] rem_q;
    logic [`VDIV_XLEN-1:0] dsr_q;
    logic neg_q_q;
    logic neg_r_q;
    logic div_zero_q;
    logic overflow_q;

    logic [`VDIV_XLEN:0] shifted;
    logic [`VDIV_XLEN:0] diff;

    // trial subtract of the divisor from the partial remainder
    assign shifted = {rem_q, quo_q[`VDIV_XLEN-1]};
    assign diff    = shifted - {1'b0, dsr_q};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= vdiv_pkg::IDLE;
            cnt_q      <= '0;
            quo_q      <= '0;
            rem_q      <= '0;
            dsr_q      <= '0;
            neg_q_q    <= 1'b0;
            neg_r_q    <= 1'b0;
            div_zero_q <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            case (state_q)
                vdiv_pkg::IDLE, vdiv_pkg::DONE: begin
                    state_q <= vdiv_pkg::IDLE;
                    if (req_i.start) begin
                        state_q    <= vdiv_pkg::RUN;
                        cnt_q      <= '0;
                        quo_q      <= req_i.dividend;
                        rem_q      <= '0;
                        dsr_q      <= req_i.divisor;
                        neg_q_q    <= req_i.neg_q;
                        neg_r_q    <= req_i.neg_r;
                        div_zero_q <= req_i.div_zero;
                        overflow_q <= req_i.overflow;
                    end
                end
                vdiv_pkg::RUN: begin
                    if (diff[`VDIV_XLEN]) begin // borrow, keep old remainder
                        rem_q <= shifted[`VDIV_XLEN-1:0];
                    end else begin
                        rem_q <= diff[`VDIV_XLEN-1:0];
                    end
                    quo_q <= {quo_q[`VDIV_XLEN-2:0], ~diff[`VDIV_XLEN]};
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`VDIV_ITERS - 1)) begin
                        state_q <= vdiv_pkg::DONE;
                    end
                end
                default: state_q <= vdiv_pkg::IDLE;
            endcase
        end
    end

    assign rsp_o.quotient  = quo_q;
    assign rsp_o.remainder = rem_q;
    assign rsp_o.valid     = (state_q == vdiv_pkg::DONE);
    assign rsp_o.neg_q     = neg_q_q;
    assign rsp_o.neg_r     = neg_r_q;
    assign rsp_o.div_zero  = div_zero_q;
    assign rsp_o.overflow  = overflow_q;

endmodule

`default_nettype wire

//--- vdiv_collect.sv
// expects all lane valids in the same cycle; opcode_i must hold until res_done_o
`timescale 1ns/1ns
`default_nettype none

`include "vdiv_params.svh"

module vdiv_collect (
    input  wire                  clk_i,
    input  wire                  arst_n_i,
    input  wire vdiv_pkg::vdiv_op_e opcode_i,
    input  wire vdiv_pkg::lane_rsp_t [`VDIV_LANES-1:0] rsp_i,
    output vdiv_pkg::vdiv_res_t  res_o,
    output logic                 res_done_o
);

    localparam logic [`VDIV_XLEN-1:0] MOST_NEG = {1'b1, {(`VDIV_XLEN-1){1'b0}}};

    logic [`VDIV_LANES-1:0] valid;
    logic is_rem;
    vdiv_pkg::vdiv_res_t res_d;

    assign is_rem = (opcode_i == vdiv_pkg::OP_REM) || (opcode_i == vdiv_pkg::OP_REMU);

    always_comb begin
        for (int i = 0; i < `VDIV_LANES; i++) begin
            logic [`VDIV_XLEN-1:0] q;
            logic [`VDIV_XLEN-1:0] r;
            logic [`VDIV_XLEN-1:0] dvd;

            valid[i] = rsp_i[i].valid;
            // with a zero divisor the lane leaves the dividend magnitude as remainder
            dvd = rsp_i[i].neg_r ? -rsp_i[i].remainder : rsp_i[i].remainder;
            if (rsp_i[i].div_zero) begin
                q = '1;
                r = dvd;
            end else if (rsp_i[i].overflow) begin
                q = MOST_NEG; // the dividend itself
                r = '0;
            end else begin
                q = rsp_i[i].neg_q ? -rsp_i[i].quotient : rsp_i[i].quotient;
                r = rsp_i[i].neg_r ? -rsp_i[i].remainder : rsp_i[i].remainder;
            end
            res_d.res[i] = is_rem ? r : q;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_o      <= '0;
            res_done_o <= 1'b0;
        end else begin
            res_done_o <= &valid;
            if (&valid) begin
                res_o <= res_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- vdiv_top.sv
// vector divider over APB; about 36 cycles from start write to done, PREADY always high
`timescale 1ns/1ns
`default_nettype none

`include "vdiv_params.svh"

module vdiv_top (
    input  wire                  clk_i,
    input  wire                  arst_n_i,
    input  wire vdiv_pkg::apb_req_t apb_i,
    output vdiv_pkg::apb_rsp_t   apb_o
);

    vdiv_pkg::vdiv_cmd_t                   cmd;
    logic                                  cmd_start;
    vdiv_pkg::lane_req_t [`VDIV_LANES-1:0] req;
    vdiv_pkg::lane_rsp_t [`VDIV_LANES-1:0] rsp;
    vdiv_pkg::vdiv_op_e                    opcode;
    vdiv_pkg::vdiv_res_t                   res;
    logic                                  res_done;

    vdiv_apb_regs u_regs (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .apb_i       (apb_i),
        .apb_o       (apb_o),
        .cmd_o       (cmd),
        .cmd_start_o (cmd_start),
        .res_i       (res),
        .res_done_i  (res_done)
    );

    vdiv_dispatch u_dispatch (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cmd_i       (cmd),
        .cmd_start_i (cmd_start),
        .req_o       (req),
        .opcode_o    (opcode)
    );

    for (genvar i = 0; i < `VDIV_LANES; i++) begin : g_lane
        vdiv_lane u_lane (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (req[i]),
            .rsp_o    (rsp[i])
        );
    end

    vdiv_collect u_collect (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .opcode_i   (opcode),
        .rsp_i      (rsp),
        .res_o      (res),
        .res_done_o (res_done)
    );

endmodule

`default_nettype wire

//--- tb_vdiv.sv
// reads vdiv_trace.txt from the working directory; one operation at a time and done found by polling
`timescale 1ns/1ns
`default_nettype none

`include "vdiv_params.svh"

module tb_vdiv;

    localparam int NAME_W = 8 * 24;
    localparam logic [7:0] ADDR_UNMAPPED = 8'h38;

    logic clk_i;
    logic arst_n_i;
    vdiv_pkg::apb_req_t apb_i;
    vdiv_pkg::apb_rsp_t apb_o;

    logic [NAME_W-1:0]   names[$];
    vdiv_pkg::vdiv_cmd_t cmds[$];
    vdiv_pkg::vdiv_res_t exps[$];

    logic [NAME_W-1:0] cur_name; // test that owns the current transfers
    int errors;
    int passed;
    int failed;
    int cycles;
    int limit;

    vdiv_top UUT (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .apb_i    (apb_i),
        .apb_o    (apb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // watchdog armed once the trace length is known
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("Test failed");
        $finish;
    end

    task automatic apb_write(input logic [7:0] addr, input logic [`VDIV_XLEN-1:0] data,
                             output logic err);
        @(posedge clk_i);
        apb_i.psel    <= 1'b1;
        apb_i.penable <= 1'b0;
        apb_i.pwrite  <= 1'b1;
        apb_i.paddr   <= addr;
        apb_i.pwdata  <= data;
        @(posedge clk_i);
        apb_i.penable <= 1'b1;
        @(negedge clk_i); // mid access phase
        err = apb_o.pslverr;
        check_ready(cur_name, apb_o.pready);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [`VDIV_XLEN-1:0] data,
                            output logic err);
        @(posedge clk_i);
        apb_i.psel    <= 1'b1;
        apb_i.penable <= 1'b0;
        apb_i.pwrite  <= 1'b0;
        apb_i.paddr   <= addr;
        apb_i.pwdata  <= '0;
        @(posedge clk_i);
        apb_i.penable <= 1'b1;
        @(negedge clk_i);
        data = apb_o.prdata;
        err  = apb_o.pslverr;
        check_ready(cur_name, apb_o.pready);
    endtask

    task automatic apb_idle();
        @(posedge clk_i);
        apb_i <= '0;
    endtask

    task automatic check_res(input logic [NAME_W-1:0] name, input vdiv_pkg::vdiv_res_t exp,
                             input vdiv_pkg::vdiv_res_t act);
        if (act !== exp) begin
            $display("ERR %0s results: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_err(input logic [NAME_W-1:0] name, input string what,
                             input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0s %0s: expected pslverr %b actual %b", name, what, exp, act);
            errors++;
        end
    endtask

    // no wait states, so every access phase must see pready high
    task automatic check_ready(input logic [NAME_W-1:0] name, input logic act);
        if (act !== 1'b1) begin
            $display("ERR %0s pready: expected 1 actual %b", name, act);
            errors++;
        end
    endtask

    task automatic check_word(input logic [NAME_W-1:0] name, input string what,
                              input logic [`VDIV_XLEN-1:0] exp,
                              input logic [`VDIV_XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERR %0s %0s: expected %h actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report(input logic [NAME_W-1:0] name, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("PASS %0s", name);
        end else begin
            failed++;
            $display("FAIL %0s", name);
        end
    endtask

    task automatic parse_op(input logic [63:0] s, output vdiv_pkg::vdiv_op_e op,
                            output logic ok);
        ok = 1'b1;
        op = vdiv_pkg::OP_DIV;
        case (s)
            64'("DIV"):  op = vdiv_pkg::OP_DIV;
            64'("DIVU"): op = vdiv_pkg::OP_DIVU;
            64'("REM"):  op = vdiv_pkg::OP_REM;
            64'("REMU"): op = vdiv_pkg::OP_REMU;
            default:     ok = 1'b0;
        endcase
    endtask

    task automatic load_trace(output logic ok);
        int fd;
        int r;
        int c;
        logic [NAME_W-1:0]     tok;
        logic [63:0]           op_s;
        logic [`VDIV_XLEN-1:0] v [12];
        vdiv_pkg::vdiv_op_e    op;
        vdiv_pkg::vdiv_cmd_t   cmd;
        vdiv_pkg::vdiv_res_t   exp;
        logic op_ok;

        ok = 1'b0;
        fd = $fopen("vdiv_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            r = $fscanf(fd, "%s", tok);
            while (r == 1 && ok) begin
                if (tok == NAME_W'("#")) begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin // up to newline
                        c = $fgetc(fd);
                    end
                end else begin
                    r = $fscanf(fd, " %s %h %h %h %h %h %h %h %h %h %h %h %h", op_s,
                                v[0], v[1], v[2], v[3], v[4], v[5],
                                v[6], v[7], v[8], v[9], v[10], v[11]);
                    parse_op(op_s, op, op_ok);
                    if (r != 13) begin
                        $display("trace line for %0s is incomplete", tok);
                        ok = 1'b0;
                    end else if (!op_ok) begin
                        $display("trace line for %0s has an unknown opcode", tok);
                        ok = 1'b0;
                    end else begin
                        cmd.opcode = op;
                        for (int i = 0; i < `VDIV_LANES; i++) begin
                            cmd.op1[i] = v[i];
                            cmd.op2[i] = v[4+i];
                            exp.res[i] = v[8+i];
                        end
                        names.push_back(tok);
                        cmds.push_back(cmd);
                        exps.push_back(exp);
                    end
                end
                r = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        if (names.size() == 0) begin
            ok = 1'b0;
        end
    endtask

    task automatic run_test(input int t);
        logic [NAME_W-1:0]     name;
        vdiv_pkg::vdiv_cmd_t   cmd;
        vdiv_pkg::vdiv_res_t   act;
        logic [`VDIV_XLEN-1:0] rdata;
        logic err;
        int errs_before;

        name        = names[t];
        cmd         = cmds[t];
        cur_name    = name;
        errs_before = errors;
        for (int i = 0; i < `VDIV_LANES; i++) begin
            apb_write(`VDIV_ADDR_OP1 + 8'(4 * i), cmd.op1[i], err);
            check_err(name, "dividend write", 1'b0, err);
            apb_write(`VDIV_ADDR_OP2 + 8'(4 * i), cmd.op2[i], err);
            check_err(name, "divisor write", 1'b0, err);
        end
        apb_write(`VDIV_ADDR_CTRL, 32'h10 | {30'b0, cmd.opcode}, err); // start bit 4
        check_err(name, "start write", 1'b0, err);

        // lanes are running now so all three must be refused
        apb_write(`VDIV_ADDR_OP1, ~cmd.op1[0], err);
        check_err(name, "dividend write while busy", 1'b1, err);
        apb_write(`VDIV_ADDR_CTRL, 32'h10 | {30'b0, ~cmd.opcode}, err);
        check_err(name, "start while busy", 1'b1, err);
        apb_read(ADDR_UNMAPPED, rdata, err);
        check_err(name, "unmapped read", 1'b1, err);

        rdata = '0;
        while (rdata[1] !== 1'b1) begin
            apb_read(`VDIV_ADDR_STAT, rdata, err);
        end
        check_word(name, "status at done", 32'h2, rdata);

        apb_read(`VDIV_ADDR_OP1, rdata, err);
        check_word(name, "dividend readback", cmd.op1[0], rdata);
        for (int i = 0; i < `VDIV_LANES; i++) begin
            apb_read(`VDIV_ADDR_RES + 8'(4 * i), rdata, err);
            check_err(name, "result read", 1'b0, err);
            act.res[i] = rdata;
        end
        apb_idle();
        check_res(name, exps[t], act);
        report(name, errs_before);
    endtask

    initial begin
        logic [`VDIV_XLEN-1:0] rdata;
        logic err;
        logic ok;
        int errs_before;

        apb_i    = '0;
        arst_n_i = 1'b0;
        errors   = 0;
        passed   = 0;
        failed   = 0;
        load_trace(ok);
        if (!ok) begin
            $display("could not read any test from vdiv_trace.txt");
            $display("Test failed");
            $finish;
        end
        limit = names.size() * 100 + 200;

        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;

        errs_before = errors;
        cur_name    = NAME_W'("reset_status");
        apb_read(`VDIV_ADDR_STAT, rdata, err);
        apb_idle();
        check_word(NAME_W'("reset_status"), "status", '0, rdata);
        check_err(NAME_W'("reset_status"), "status read", 1'b0, err);
        report(NAME_W'("reset_status"), errs_before);

        for (int t = 0; t < names.size(); t++) begin
            run_test(t);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vdiv_trace.txt
# name opcode dividend[0..3] divisor[0..3] expected[0..3]
# all operand and result columns are 32-bit hex, opcode is DIV DIVU REM or REMU
div_signed DIV 00000007 FFFFFFF9 00000007 FFFFFFF9 00000002 00000002 FFFFFFFE FFFFFFFE 00000003 FFFFFFFD FFFFFFFD 00000003
rem_signed REM 00000007 FFFFFFF9 00000007 FFFFFFF9 00000002 00000002 FFFFFFFE FFFFFFFE 00000001 FFFFFFFF 00000001 FFFFFFFF
div_signed_wide DIV 000F4240 FFFFFF9C 7FFFFFFF 80000001 00000007 00000009 00010000 00000002 00022E09 FFFFFFF5 00007FFF C0000001
rem_signed_wide REM 000F4240 FFFFFF9C 7FFFFFFF 80000001 00000007 00000009 00010000 00000002 00000001 FFFFFFFF 0000FFFF FFFFFFFF
divu_top_bit DIVU FFFFFFFF 80000000 FFFFFFF9 12345678 00000002 FFFFFFFF 00000010 80000000 7FFFFFFF 00000000 0FFFFFFF 00000000
remu_top_bit REMU FFFFFFFF 80000000 FFFFFFF9 12345678 00000002 FFFFFFFF 00000010 80000000 00000001 80000000 00000009 12345678
div_by_zero DIV 00000005 FFFFFFF6 FFFFFF9C 80000000 00000000 00000003 00000000 00000010 FFFFFFFF FFFFFFFD FFFFFFFF F8000000
rem_by_zero REM 00000005 FFFFFFF6 FFFFFF9C 80000000 00000000 00000003 00000000 00000010 00000005 FFFFFFFF FFFFFF9C 00000000
divu_by_zero DIVU FFFFFFF6 00000009 00000064 80000000 00000000 00000002 00000000 00000003 FFFFFFFF 00000004 FFFFFFFF 2AAAAAAA
remu_by_zero REMU FFFFFFF6 00000009 00000064 80000000 00000000 00000002 00000000 00000003 FFFFFFF6 00000001 00000064 00000002
div_overflow DIV 80000000 80000000 80000000 7FFFFFFF FFFFFFFF 00000001 FFFFFFFF FFFFFFFF 80000000 80000000 80000000 80000001
rem_overflow REM 80000000 80000000 80000000 7FFFFFFF FFFFFFFF 00000001 FFFFFFFF FFFFFFFF 00000000 00000000 00000000 00000000
divu_overflow_ops DIVU 80000000 80000000 7FFFFFFF FFFFFFFF FFFFFFFF 00000001 FFFFFFFF FFFFFFFF 00000000 80000000 00000000 00000001
remu_overflow_ops REMU 80000000 80000000 7FFFFFFF FFFFFFFF FFFFFFFF 00000001 FFFFFFFF FFFFFFFF 80000000 00000000 7FFFFFFF 00000000

//--- verilog.f
+incdir+.
vdiv_pkg.sv
vdiv_apb_regs.sv
vdiv_dispatch.sv
vdiv_lane.sv
vdiv_collect.sv
vdiv_top.sv
tb_vdiv.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_vdiv
FILELIST  = verilog.f
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
